// File: div_reuse_tracker.sv
/*
 * Saved divide source addresses and the flag that lets
 * a repeated divide reuse the previous result
 */
`timescale 1ns/100ps

module div_reuse_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  issue_pkg::word_t     instruction,
    input  logic                 instr_pop,
    input  logic                 writes_rd,
    input  issue_pkg::unit_vec_t unit_issue,
    output logic                 div_reuse
);

    issue_pkg::reg_addr_t rd_addr;
    issue_pkg::reg_addr_t rs1_addr;
    issue_pkg::reg_addr_t rs2_addr;
    issue_pkg::reg_addr_t prev_rs1_addr;
    issue_pkg::reg_addr_t prev_rs2_addr;
    logic                 div_issue;
    logic                 rd_hits_own_sources;
    logic                 rd_hits_saved_sources;
    logic                 same_sources;
    logic                 reuse_valid;

    assign rd_addr   = instruction[11:7];
    assign rs1_addr  = instruction[19:15];
    assign rs2_addr  = instruction[24:20];
    assign div_issue = unit_issue[issue_pkg::UNIT_DIV];

    assign rd_hits_own_sources   = (rd_addr == rs1_addr) || (rd_addr == rs2_addr);
    assign rd_hits_saved_sources = (rd_addr == prev_rs1_addr) || (rd_addr == prev_rs2_addr);
    assign same_sources          = (rs1_addr == prev_rs1_addr) && (rs2_addr == prev_rs2_addr);

    always_ff @(posedge clk) begin
        if (div_issue) begin
            prev_rs1_addr <= rs1_addr;
            prev_rs2_addr <= rs2_addr;
        end
    end

    //////////////////////////////
    // Reuse valid
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            reuse_valid <= 1'b0;
        end else if (div_issue) begin
            reuse_valid <= ~rd_hits_own_sources;
        end else if (instr_pop && writes_rd && rd_hits_saved_sources) begin
            reuse_valid <= 1'b0;
        end
    end

    assign div_reuse = div_issue & reuse_valid & same_sources;

    // Reuse only ever rides on an actual divide pop from issue control
    reuse_on_div_issue: assert property (
        @(posedge clk) disable iff (rst)
        div_reuse |-> (instr_pop && unit_issue == (1 << issue_pkg::UNIT_DIV))
    );

endmodule

// File: instr_classifier.sv
/*
 * Opcode decode into a one-hot unit request,
 * register-write, load, store and illegal flags
 */
`timescale 1ns/100ps

module instr_classifier (
    input  issue_pkg::word_t     instruction,
    output issue_pkg::unit_vec_t unit_request,
    output logic                 writes_rd,
    output logic                 is_store,
    output logic                 is_load,
    output logic                 illegal_instruction
);

    issue_pkg::opcode_trim_t opcode_trim;
    issue_pkg::fn3_t         fn3;
    issue_pkg::reg_addr_t    rd_addr;
    logic                    mult_div_op;
    logic                    has_rd;

    assign opcode_trim = issue_pkg::opcode_trim_t'(instruction[6:2]);
    assign fn3         = instruction[14:12];
    assign rd_addr     = instruction[11:7];
    assign mult_div_op = instruction[25];

    always_comb begin
        unit_request        = '0;
        illegal_instruction = 1'b0;
        has_rd              = 1'b0;
        case (opcode_trim)
            issue_pkg::BRANCH_T: unit_request[issue_pkg::UNIT_BRANCH] = 1'b1;
            issue_pkg::JAL_T, issue_pkg::JALR_T: begin
                unit_request[issue_pkg::UNIT_BRANCH] = 1'b1;
                has_rd = 1'b1;
            end
            issue_pkg::LOAD_T: begin
                unit_request[issue_pkg::UNIT_LS] = 1'b1;
                has_rd = 1'b1;
            end
            issue_pkg::STORE_T: unit_request[issue_pkg::UNIT_LS] = 1'b1;
            issue_pkg::ARITH_T: begin
                // M extension space, only the divide half exists here
                if (mult_div_op && fn3[2]) begin
                    unit_request[issue_pkg::UNIT_DIV] = 1'b1;
                    has_rd = 1'b1;
                end else if (mult_div_op) begin
                    illegal_instruction = 1'b1;
                end else begin
                    unit_request[issue_pkg::UNIT_ALU] = 1'b1;
                    has_rd = 1'b1;
                end
            end
            issue_pkg::ARITH_IMM_T, issue_pkg::LUI_T, issue_pkg::AUIPC_T: begin
                unit_request[issue_pkg::UNIT_ALU] = 1'b1;
                has_rd = 1'b1;
            end
            // No global-control unit in this stage
            issue_pkg::FENCE_T, issue_pkg::SYSTEM_T: illegal_instruction = 1'b1;
            default: illegal_instruction = 1'b1;
        endcase
    end

    // x0 is never a tracked destination
    assign writes_rd = has_rd & (rd_addr != '0);
    assign is_load   = (opcode_trim == issue_pkg::LOAD_T);
    assign is_store  = (opcode_trim == issue_pkg::STORE_T);

    unit_request_onehot: assert final ($onehot0(unit_request));

endmodule

// File: issue_control.sv
/*
 * Issue decision for the presented instruction: operand
 * readiness with the store-data forward exception, unit ready and hold
 */
`timescale 1ns/100ps

module issue_control (
    input  logic                 instr_valid,
    input  logic                 issue_hold,
    input  logic                 illegal_instruction,
    input  logic                 is_store,
    input  logic                 rs1_conflict,
    input  logic                 rs2_conflict,
    input  logic                 forward_possible,
    input  issue_pkg::unit_vec_t unit_request,
    input  issue_pkg::unit_vec_t unit_ready,
    output logic                 instr_pop,
    output issue_pkg::unit_vec_t unit_issue
);

    logic issue_valid;
    logic target_ready;
    logic rs2_ready;
    logic operands_ready;

    //////////////////////////////
    // Issue conditions
    //////////////////////////////
    assign issue_valid  = instr_valid & ~issue_hold & ~illegal_instruction;
    assign target_ready = |(unit_request & unit_ready);

    // A store may go while its data is still coming from the last load,
    // the load-store unit picks it up from the load result
    assign rs2_ready      = ~rs2_conflict | (is_store & forward_possible);
    assign operands_ready = ~rs1_conflict & rs2_ready;

    //////////////////////////////
    // Issue pulse
    //////////////////////////////
    assign instr_pop  = issue_valid & target_ready & operands_ready;
    assign unit_issue = {issue_pkg::NUM_UNITS{instr_pop}} & unit_request;

    pop_needs_valid: assert final (!instr_pop || instr_valid);
    issue_onehot: assert final (!instr_pop || $onehot(unit_issue));

endmodule

// File: issue_pkg.sv
/*
 * Shared widths, register and opcode types, unit indices and
 * the load-store access code for the decode and issue stage
 */
package issue_pkg;

    //////////////////////////////
    // Widths and basic types
    //////////////////////////////
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // Operand word with one extension bit on top for signed compares
    typedef logic [XLEN:0] alu_operand_t;

    typedef logic [4:0] reg_addr_t;
    typedef logic [2:0] fn3_t;

    //////////////////////////////
    // Opcode bits 6 to 2
    //////////////////////////////
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011,
        SYSTEM_T    = 5'b11100
    } opcode_trim_t;

    //////////////////////////////
    // Execution units
    //////////////////////////////
    localparam int UNIT_ALU    = 0;
    localparam int UNIT_LS     = 1;
    localparam int UNIT_BRANCH = 2;
    localparam int UNIT_DIV    = 3;

    localparam int NUM_UNITS = 4;

    // One bit per unit, at most one set for a request
    typedef logic [NUM_UNITS-1:0] unit_vec_t;

    //////////////////////////////
    // Load-store access size
    //////////////////////////////
    localparam fn3_t LS_W_FN3 = 3'b010;

endpackage

// File: issue_stage_top.sv
/*
 * Decode and issue stage: classifier, issue control,
 * both trackers and the operand generator
 */
`timescale 1ns/100ps

module issue_stage_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  issue_pkg::word_t        instruction,
    input  issue_pkg::word_t        pc,
    input  issue_pkg::word_t        rs1_data,
    input  issue_pkg::word_t        rs2_data,
    input  logic                    rs1_conflict,
    input  logic                    rs2_conflict,
    input  issue_pkg::unit_vec_t    unit_ready,
    input  logic                    issue_hold,
    output logic                    instr_pop,
    output issue_pkg::unit_vec_t    unit_issue,
    output logic                    illegal_instruction,
    output logic                    div_reuse,
    output issue_pkg::alu_operand_t alu_in1,
    output issue_pkg::alu_operand_t alu_in2,
    output issue_pkg::word_t        ls_address,
    output issue_pkg::fn3_t         ls_fn3,
    output logic                    ls_load,
    output logic                    ls_store,
    output logic                    ls_forward
);

    issue_pkg::unit_vec_t unit_request;
    logic                 writes_rd;
    logic                 is_store;
    logic                 is_load;
    logic                 forward_possible;

    instr_classifier classifier0 (
        .instruction(instruction), .unit_request(unit_request), .writes_rd(writes_rd),
        .is_store(is_store), .is_load(is_load), .illegal_instruction(illegal_instruction)
    );

    issue_control control0 (
        .instr_valid(instr_valid), .issue_hold(issue_hold),
        .illegal_instruction(illegal_instruction), .is_store(is_store),
        .rs1_conflict(rs1_conflict), .rs2_conflict(rs2_conflict),
        .forward_possible(forward_possible), .unit_request(unit_request),
        .unit_ready(unit_ready), .instr_pop(instr_pop), .unit_issue(unit_issue)
    );

    load_forward_tracker load_fwd0 (
        .clk(clk), .rst(rst), .instruction(instruction), .instr_pop(instr_pop),
        .writes_rd(writes_rd), .is_load(is_load), .is_store(is_store),
        .forward_possible(forward_possible)
    );

    div_reuse_tracker div_reuse0 (
        .clk(clk), .rst(rst), .instruction(instruction), .instr_pop(instr_pop),
        .writes_rd(writes_rd), .unit_issue(unit_issue), .div_reuse(div_reuse)
    );

    unit_operand_gen operands0 (
        .instruction(instruction), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs2_conflict(rs2_conflict), .is_store(is_store), .is_load(is_load),
        .alu_in1(alu_in1), .alu_in2(alu_in2), .ls_address(ls_address), .ls_fn3(ls_fn3),
        .ls_load(ls_load), .ls_store(ls_store), .ls_forward(ls_forward)
    );

endmodule

// File: load_forward_tracker.sv
/*
 * Per-register written-by-load bits and the destination
 * of the most recent load, giving the store forward condition
 */
`timescale 1ns/100ps

module load_forward_tracker (
    input  logic             clk,
    input  logic             rst,
    input  issue_pkg::word_t instruction,
    input  logic             instr_pop,
    input  logic             writes_rd,
    input  logic             is_load,
    input  logic             is_store,
    output logic             forward_possible
);

    issue_pkg::reg_addr_t rd_addr;
    issue_pkg::reg_addr_t rs2_addr;
    issue_pkg::reg_addr_t last_load_rd;
    logic [31:0]          written_by_load;

    assign rd_addr  = instruction[11:7];
    assign rs2_addr = instruction[24:20];

    // Every issued writer records whether it was a load
    always_ff @(posedge clk) begin
        if (rst) begin
            written_by_load <= '0;
        end else if (instr_pop && writes_rd) begin
            written_by_load[rd_addr] <= is_load;
        end
    end

    // Loads to x0 still count as the latest load
    always_ff @(posedge clk) begin
        if (instr_pop && is_load) begin
            last_load_rd <= rd_addr;
        end
    end

    assign forward_possible = is_store & written_by_load[rs2_addr] &
                              (last_load_rd == rs2_addr);

endmodule

// File: tb.f
+incdir+.
issue_pkg.sv
instr_classifier.sv
issue_control.sv
load_forward_tracker.sv
div_reuse_tracker.sv
unit_operand_gen.sv
issue_stage_top.sv
tb_issue_stage.sv

// File: tb_issue_ref.svh
/*
 * Reference model of the issue stage: shadow tracker state,
 * expected outputs and the shadow update on a predicted issue
 */
`ifndef TB_ISSUE_REF_SVH
`define TB_ISSUE_REF_SVH

typedef struct packed {
    logic                    pop;
    issue_pkg::unit_vec_t    issue;
    logic                    illegal;
    logic                    reuse;
    issue_pkg::alu_operand_t in1;
    issue_pkg::alu_operand_t in2;
    issue_pkg::word_t        addr;
    issue_pkg::fn3_t         fn3;
    logic                    load;
    logic                    store;
    logic                    fwd;
} expect_t;

// Shadow of both trackers, moved only by a predicted issue
logic [31:0]          load_wrote;
issue_pkg::reg_addr_t newest_load_rd;
issue_pkg::reg_addr_t saved_rs1;
issue_pkg::reg_addr_t saved_rs2;
logic                 reuse_ok;

function automatic void clear_shadow();
    load_wrote     = '0;
    newest_load_rd = '0;
    saved_rs1      = '0;
    saved_rs2      = '0;
    reuse_ok       = 1'b0;
endfunction

function automatic expect_t predict_outputs(
    input issue_pkg::word_t     ins, pc_v, d1, d2,
    input logic                 valid, hold, c1, c2,
    input issue_pkg::unit_vec_t ready
);
    expect_t     e;
    logic [4:0]  op;
    logic [2:0]  f3;
    logic [11:0] offs;
    logic [31:0] a1;
    logic [31:0] a2;
    logic        fwd_ok;
    int          unit;
    op   = ins[6:2];
    f3   = ins[14:12];
    e    = '0;
    unit = -1;
    case (op)
        issue_pkg::BRANCH_T, issue_pkg::JAL_T, issue_pkg::JALR_T: unit = issue_pkg::UNIT_BRANCH;
        issue_pkg::LOAD_T, issue_pkg::STORE_T: unit = issue_pkg::UNIT_LS;
        issue_pkg::ARITH_IMM_T, issue_pkg::LUI_T, issue_pkg::AUIPC_T: unit = issue_pkg::UNIT_ALU;
        // Bit 25 selects the M space, where only divides exist
        issue_pkg::ARITH_T: begin
            if (!ins[25]) unit = issue_pkg::UNIT_ALU;
            else if (f3[2]) unit = issue_pkg::UNIT_DIV;
        end
        default: unit = -1;
    endcase
    e.store   = (op == issue_pkg::STORE_T);
    e.load    = (op == issue_pkg::LOAD_T);
    e.illegal = (unit < 0);
    e.fwd     = e.store & c2;
    // Store data may come straight from the newest load
    fwd_ok = e.store && load_wrote[ins[24:20]] && newest_load_rd == ins[24:20];
    if (unit >= 0) begin
        e.pop = valid && !hold && ready[unit] && !c1 && (!c2 || fwd_ok);
        if (e.pop) e.issue[unit] = 1'b1;
    end
    e.reuse = e.pop && unit == issue_pkg::UNIT_DIV && reuse_ok &&
              ins[19:15] == saved_rs1 && ins[24:20] == saved_rs2;
    case (op)
        issue_pkg::LUI_T: a1 = '0;
        issue_pkg::AUIPC_T, issue_pkg::JAL_T, issue_pkg::JALR_T: a1 = pc_v;
        default: a1 = d1;
    endcase
    case (op)
        issue_pkg::LUI_T, issue_pkg::AUIPC_T: a2 = {ins[31:12], 12'h000};
        issue_pkg::ARITH_IMM_T: a2 = {{20{ins[31]}}, ins[31:20]};
        issue_pkg::JAL_T, issue_pkg::JALR_T: a2 = 32'd4;
        default: a2 = d2;
    endcase
    // Unsigned forms (fn3 bit 0 set) get a zero on top
    e.in1  = {a1[31] & ~f3[0], a1};
    e.in2  = {a2[31] & ~f3[0], a2};
    offs   = e.store ? {ins[31:25], ins[11:7]} : ins[31:20];
    e.addr = d1 + {{20{offs[11]}}, offs};
    e.fn3  = f3;
    return e;
endfunction

function automatic void update_shadow(input issue_pkg::word_t ins, input expect_t e);
    logic [4:0] op;
    logic [4:0] rd;
    logic       writer;
    op = ins[6:2];
    rd = ins[11:7];
    // An issued word is legal, so only branch and store lack a destination
    writer = e.pop && rd != 5'd0 && op != issue_pkg::BRANCH_T && op != issue_pkg::STORE_T;
    if (writer) load_wrote[rd] = (op == issue_pkg::LOAD_T);
    if (e.pop && op == issue_pkg::LOAD_T) newest_load_rd = rd;
    if (e.issue[issue_pkg::UNIT_DIV]) begin
        reuse_ok  = rd != ins[19:15] && rd != ins[24:20];
        saved_rs1 = ins[19:15];
        saved_rs2 = ins[24:20];
    end else if (writer && (rd == saved_rs1 || rd == saved_rs2)) begin
        reuse_ok = 1'b0;
    end
endfunction

`endif

// File: tb_issue_stage.sv
/*
 * Testbench for the issue stage with directed forward and reuse
 * sequences, random stimulus and a per-cycle reference compare
 */
`timescale 1ns/100ps

module tb_issue_stage;

    localparam int RANDOM_CYCLES = 600;
    // Reset, about 20 directed cycles and the random run, with margin
    localparam int MAX_CYCLES    = 800;

    localparam issue_pkg::word_t LW_X5   = {12'h010, 5'd1, issue_pkg::LS_W_FN3, 5'd5, 7'h03};
    localparam issue_pkg::word_t LW_X6   = {12'h004, 5'd1, issue_pkg::LS_W_FN3, 5'd6, 7'h03};
    localparam issue_pkg::word_t SW_X5   = {7'h00, 5'd5, 5'd2, issue_pkg::LS_W_FN3, 5'd8, 7'h23};
    localparam issue_pkg::word_t DIV_X3  = {7'h01, 5'd2, 5'd1, 3'b100, 5'd3, 7'h33};
    localparam issue_pkg::word_t ADDI_X1 = {12'd5, 5'd0, 3'b000, 5'd1, 7'h13};

    logic                    clk;
    logic                    rst;
    logic                    instr_valid;
    issue_pkg::word_t        instruction;
    issue_pkg::word_t        pc;
    issue_pkg::word_t        rs1_data;
    issue_pkg::word_t        rs2_data;
    logic                    rs1_conflict;
    logic                    rs2_conflict;
    issue_pkg::unit_vec_t    unit_ready;
    logic                    issue_hold;
    logic                    instr_pop;
    issue_pkg::unit_vec_t    unit_issue;
    logic                    illegal_instruction;
    logic                    div_reuse;
    issue_pkg::alu_operand_t alu_in1;
    issue_pkg::alu_operand_t alu_in2;
    issue_pkg::word_t        ls_address;
    issue_pkg::fn3_t         ls_fn3;
    logic                    ls_load;
    logic                    ls_store;
    logic                    ls_forward;
    int                      errors = 0;
    int                      cycles = 0;

    `include "tb_issue_ref.svh"

    expect_t last_exp;

    issue_stage_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic word_compare(input string what, input issue_pkg::word_t got, want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic operand_compare(input string what, input issue_pkg::alu_operand_t got, want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic units_compare(input string what, input issue_pkg::unit_vec_t got, want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic fn3_compare(input string what, input issue_pkg::fn3_t got, want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic bit_compare(input string what, input logic got, want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // Outputs settle after the rising edge, so look at them mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            clear_shadow();
            last_exp = '0;
        end else begin
            last_exp = predict_outputs(instruction, pc, rs1_data, rs2_data, instr_valid,
                                       issue_hold, rs1_conflict, rs2_conflict, unit_ready);
            bit_compare("instr_pop", instr_pop, last_exp.pop);
            units_compare("unit_issue", unit_issue, last_exp.issue);
            bit_compare("illegal_instruction", illegal_instruction, last_exp.illegal);
            bit_compare("div_reuse", div_reuse, last_exp.reuse);
            operand_compare("alu_in1", alu_in1, last_exp.in1);
            operand_compare("alu_in2", alu_in2, last_exp.in2);
            word_compare("ls_address", ls_address, last_exp.addr);
            fn3_compare("ls_fn3", ls_fn3, last_exp.fn3);
            bit_compare("ls_load", ls_load, last_exp.load);
            bit_compare("ls_store", ls_store, last_exp.store);
            bit_compare("ls_forward", ls_forward, last_exp.fwd);
            update_shadow(instruction, last_exp);
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    function automatic issue_pkg::word_t random_instruction();
        issue_pkg::word_t w;
        logic [4:0]       op;
        case ($urandom_range(12))
            0: op = issue_pkg::LOAD_T;
            1: op = issue_pkg::STORE_T;
            2: op = issue_pkg::ARITH_IMM_T;
            3: op = issue_pkg::LUI_T;
            4: op = issue_pkg::AUIPC_T;
            5: op = issue_pkg::BRANCH_T;
            6: op = issue_pkg::JAL_T;
            7: op = issue_pkg::JALR_T;
            8: op = issue_pkg::FENCE_T;
            9: op = issue_pkg::SYSTEM_T;
            10: op = 5'b01011;
            default: op = issue_pkg::ARITH_T;
        endcase
        w      = $urandom();
        w[6:0] = {op, 2'b11};
        // Registers x0 to x7 only, so hazards come often
        w[11:7]  = $urandom_range(7);
        w[19:15] = $urandom_range(7);
        w[24:20] = $urandom_range(7);
        return w;
    endfunction

    task automatic drive_controls();
        issue_hold   <= ($urandom_range(7) == 0);
        rs1_conflict <= ($urandom_range(3) == 0);
        rs2_conflict <= ($urandom_range(3) == 0);
        // Each ready bit high three times in four
        unit_ready   <= issue_pkg::unit_vec_t'($urandom() | $urandom());
    endtask

    task automatic issue_directed(input issue_pkg::word_t ins, input logic c2,
                                  output logic at_once, output logic reuse);
        @(posedge clk);
        instruction  <= ins;
        instr_valid  <= 1'b1;
        issue_hold   <= 1'b0;
        rs1_conflict <= 1'b0;
        rs2_conflict <= c2;
        unit_ready   <= '1;
        @(negedge clk);
        at_once = instr_pop;
        while (!instr_pop) begin
            @(negedge clk);
        end
        reuse = div_reuse;
    endtask

    task automatic forward_sequence();
        logic at_once;
        logic reuse;
        issue_directed(LW_X5, 1'b0, at_once, reuse);
        issue_directed(SW_X5, 1'b1, at_once, reuse);
        bit_compare("store forwarded from newest load", at_once, 1'b1);
        // A newer load to x6 ends the forward window for x5
        issue_directed(LW_X5, 1'b0, at_once, reuse);
        issue_directed(LW_X6, 1'b0, at_once, reuse);
        @(posedge clk);
        instruction  <= SW_X5;
        rs2_conflict <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            bit_compare("store held behind newer load", instr_pop, 1'b0);
        end
        issue_directed(SW_X5, 1'b0, at_once, reuse);
    endtask

    task automatic reuse_sequence();
        logic at_once;
        logic reuse;
        issue_directed(DIV_X3, 1'b0, at_once, reuse);
        issue_directed(DIV_X3, 1'b0, at_once, reuse);
        bit_compare("repeated divide reuses result", reuse, 1'b1);
        issue_directed(ADDI_X1, 1'b0, at_once, reuse);
        issue_directed(DIV_X3, 1'b0, at_once, reuse);
        bit_compare("divide after source write", reuse, 1'b0);
    endtask

    task automatic random_sequence();
        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            // A stalled legal word stays presented until it pops
            if (!instr_valid || last_exp.pop || last_exp.illegal) begin
                instruction <= random_instruction();
                pc          <= $urandom() & 32'hffff_fffc;
                rs1_data    <= $urandom();
                rs2_data    <= $urandom();
                instr_valid <= ($urandom_range(7) != 0);
            end
            drive_controls();
        end
    endtask

    initial begin
        void'($urandom(93));
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instruction  = '0;
        pc           = 32'h0000_1000;
        rs1_data     = 32'h0000_2000;
        rs2_data     = 32'h1234_5678;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        unit_ready   = '0;
        issue_hold   = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        forward_sequence();
        reuse_sequence();
        random_sequence();
        @(posedge clk);
        instr_valid <= 1'b0;
        // The last mid-cycle compare is done by the next rising edge
        @(posedge clk);
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: unit_operand_gen.sv
/*
 * ALU operand selection with extension bits, and the
 * load-store address, access code and direction
 */
`timescale 1ns/100ps

module unit_operand_gen (
    input  issue_pkg::word_t        instruction,
    input  issue_pkg::word_t        pc,
    input  issue_pkg::word_t        rs1_data,
    input  issue_pkg::word_t        rs2_data,
    input  logic                    rs2_conflict,
    input  logic                    is_store,
    input  logic                    is_load,
    output issue_pkg::alu_operand_t alu_in1,
    output issue_pkg::alu_operand_t alu_in2,
    output issue_pkg::word_t        ls_address,
    output issue_pkg::fn3_t         ls_fn3,
    output logic                    ls_load,
    output logic                    ls_store,
    output logic                    ls_forward
);

    issue_pkg::opcode_trim_t opcode_trim;
    issue_pkg::fn3_t         fn3;
    issue_pkg::word_t        alu_rs1;
    issue_pkg::word_t        alu_rs2;
    logic [11:0]             ls_offset;

    assign opcode_trim = issue_pkg::opcode_trim_t'(instruction[6:2]);
    assign fn3         = instruction[14:12];

    //////////////////////////////
    // ALU operands
    //////////////////////////////
    always_comb begin
        case (opcode_trim)
            issue_pkg::LUI_T: alu_rs1 = '0;
            issue_pkg::AUIPC_T, issue_pkg::JAL_T, issue_pkg::JALR_T: alu_rs1 = pc;
            default: alu_rs1 = rs1_data;
        endcase
        case (opcode_trim)
            issue_pkg::LUI_T, issue_pkg::AUIPC_T: alu_rs2 = {instruction[31:12], 12'b0};
            issue_pkg::ARITH_IMM_T: alu_rs2 = issue_pkg::word_t'(signed'(instruction[31:20]));
            issue_pkg::JAL_T, issue_pkg::JALR_T: alu_rs2 = 32'd4;
            default: alu_rs2 = rs2_data;
        endcase
    end

    // fn3 bit 0 marks the unsigned compares, which get a zero extension
    assign alu_in1 = {alu_rs1[issue_pkg::XLEN-1] & ~fn3[0], alu_rs1};
    assign alu_in2 = {alu_rs2[issue_pkg::XLEN-1] & ~fn3[0], alu_rs2};

    //////////////////////////////
    // Load-store bundle
    //////////////////////////////
    assign ls_offset  = is_store ? {instruction[31:25], instruction[11:7]} : instruction[31:20];
    assign ls_address = rs1_data + issue_pkg::word_t'(signed'(ls_offset));
    assign ls_fn3     = fn3;
    assign ls_load    = is_load;
    assign ls_store   = is_store;
    assign ls_forward = is_store & rs2_conflict;

endmodule
